// File: filelist.f
logic/mmu_pkg.sv
logic/xlate_csr.sv
logic/tlb.sv
logic/addr_xlate.sv
logic/mmu_top.sv
tests/tb_mmu_top.sv

// File: logic/addr_xlate.sv
`timescale 1ns/100ps
`default_nettype none

module addr_xlate #(
        parameter bit FETCH_PORT = 1'b1
) (
        input  wire                             access_valid,
        input  wire                             store,
        input  wire [mmu_pkg::VADDR_W-1:0]      vaddr,
        input  mmu_pkg::crmd_t                  crmd,
        input  wire [mmu_pkg::ASID_W-1:0]       asid,
        input  mmu_pkg::dmw_t                   dmw0,
        input  mmu_pkg::dmw_t                   dmw1,
        input  mmu_pkg::tlb_search_rsp_t        tlb_rsp,
        output mmu_pkg::tlb_search_req_t        tlb_req,
        output mmu_pkg::xlate_result_t          result
);

        import mmu_pkg::*;

        logic      dmw0_hit;
        logic      dmw1_hit;
        tlb_page_t page;

        function automatic logic window_hit(input dmw_t dmw,
                                            input logic [2:0] seg,
                                            input logic [1:0] plv);
                logic plv_ok;

                plv_ok = (plv == 2'd0 && dmw.plv0) || (plv == 2'd3 && dmw.plv3);
                return plv_ok && (dmw.vseg == seg);
        endfunction

        always_comb begin
                tlb_req.vppn     = vaddr[VADDR_W-1:13];
                tlb_req.va_bit12 = vaddr[12];
                tlb_req.asid     = asid;
        end

        assign dmw0_hit = window_hit(dmw0, vaddr[31:29], crmd.plv);
        assign dmw1_hit = window_hit(dmw1, vaddr[31:29], crmd.plv);
        assign page     = tlb_rsp.page;

        always_comb begin
                result = '0;
                if (crmd.da) begin
                        result.paddr = vaddr;
                        if (FETCH_PORT) begin
                                result.cacheable = (crmd.datf == 2'd1);
                        end else begin
                                result.cacheable = (crmd.datm == 2'd1);
                        end
                end else if (dmw0_hit) begin
                        result.paddr     = {dmw0.pseg, vaddr[28:0]};
                        result.cacheable = (dmw0.mat == 2'd1);
                end else if (dmw1_hit) begin
                        result.paddr     = {dmw1.pseg, vaddr[28:0]};
                        result.cacheable = (dmw1.mat == 2'd1);
                end else begin
                        if (tlb_rsp.ps == PS_2M) begin
                                result.paddr = {page.ppn[PPN_W-1:9], vaddr[20:0]};
                        end else begin
                                result.paddr = {page.ppn, vaddr[11:0]};
                        end
                        result.cacheable = (page.mat == 2'd1);

                        // one fault at most, in priority order
                        if (access_valid) begin
                                if (!tlb_rsp.found) begin
                                        result.exc.tlbr = 1'b1;
                                end else if (!page.v) begin
                                        if (FETCH_PORT) begin
                                                result.exc.pif = 1'b1;
                                        end else if (store) begin
                                                result.exc.pis = 1'b1;
                                        end else begin
                                                result.exc.pil = 1'b1;
                                        end
                                end else if (crmd.plv > page.plv) begin
                                        result.exc.ppi = 1'b1;
                                end else if (!FETCH_PORT && store && !page.d) begin
                                        result.exc.pme = 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// File: logic/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

        localparam int VADDR_W     = 32;
        localparam int VPPN_W      = 19;
        localparam int PPN_W       = 20;
        localparam int ASID_W      = 10;
        localparam int TLB_ENTRIES = 16;
        localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

        // page size codes, log2 of the page size
        localparam logic [5:0] PS_4K = 6'd12;
        localparam logic [5:0] PS_2M = 6'd21;

        typedef logic [13:0] csr_num_t;

        localparam csr_num_t CSR_CRMD = 14'h000;
        localparam csr_num_t CSR_ASID = 14'h018;
        localparam csr_num_t CSR_DMW0 = 14'h180;
        localparam csr_num_t CSR_DMW1 = 14'h181;

        // laid out as in the crmd word, bit 0 up
        typedef struct packed {
                logic       spare;
                logic [1:0] datm;
                logic [1:0] datf;
                logic       pg;
                logic       da;
                logic       ie;
                logic [1:0] plv;
        } crmd_t;

        typedef struct packed {
                logic [2:0] vseg;
                logic [2:0] pseg;
                logic [1:0] spare;
                logic [1:0] mat;
                logic       plv3;
                logic       plv0;
        } dmw_t;

        typedef struct packed {
                logic [PPN_W-1:0] ppn;
                logic [1:0]       plv;
                logic [1:0]       mat;
                logic             d;
                logic             v;
        } tlb_page_t;

        // page[0] even, page[1] odd
        typedef struct packed {
                logic              e;
                logic [VPPN_W-1:0] vppn;
                logic [5:0]        ps;
                logic [ASID_W-1:0] asid;
                logic              g;
                tlb_page_t [1:0]   page;
        } tlb_entry_t;

        typedef struct packed {
                logic [VPPN_W-1:0] vppn;
                logic              va_bit12;
                logic [ASID_W-1:0] asid;
        } tlb_search_req_t;

        typedef struct packed {
                logic                 found;
                logic [TLB_IDX_W-1:0] index;
                logic [5:0]           ps;
                tlb_page_t            page;
        } tlb_search_rsp_t;

        typedef struct packed {
                logic tlbr;
                logic pif;
                logic pil;
                logic pis;
                logic pme;
                logic ppi;
        } xlate_exc_t;

        typedef struct packed {
                logic [VADDR_W-1:0] paddr;
                logic               cacheable;
                xlate_exc_t         exc;
        } xlate_result_t;

endpackage

`default_nettype wire

// File: logic/mmu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_top #(
        parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES
) (
        input  wire                             clk,
        input  wire                             reset,
        input  wire                             csr_we,
        input  mmu_pkg::csr_num_t               csr_num,
        input  wire [31:0]                      csr_wdata,
        input  wire                             tlb_we,
        input  wire [$clog2(TLB_ENTRIES)-1:0]   tlb_windex,
        input  mmu_pkg::tlb_entry_t             tlb_wentry,
        input  wire [mmu_pkg::VADDR_W-1:0]      fetch_vaddr,
        input  wire                             data_valid,
        input  wire                             data_store,
        input  wire [mmu_pkg::VADDR_W-1:0]      data_vaddr,
        output mmu_pkg::xlate_result_t          fetch_res,
        output mmu_pkg::xlate_result_t          data_res
);

        import mmu_pkg::*;

        crmd_t             crmd;
        logic [ASID_W-1:0] asid;
        dmw_t              dmw0;
        dmw_t              dmw1;
        tlb_search_req_t   s0_req;
        tlb_search_req_t   s1_req;
        tlb_search_rsp_t   s0_rsp;
        tlb_search_rsp_t   s1_rsp;

        xlate_csr xlate_csr0 (
                .clk       (clk),
                .reset     (reset),
                .csr_we    (csr_we),
                .csr_num   (csr_num),
                .csr_wdata (csr_wdata),
                .crmd      (crmd),
                .asid      (asid),
                .dmw0      (dmw0),
                .dmw1      (dmw1)
        );

        tlb #(
                .TLB_ENTRIES (TLB_ENTRIES)
        ) tlb0 (
                .clk        (clk),
                .reset      (reset),
                .tlb_we     (tlb_we),
                .tlb_windex (tlb_windex),
                .tlb_wentry (tlb_wentry),
                .s0_req     (s0_req),
                .s1_req     (s1_req),
                .s0_rsp     (s0_rsp),
                .s1_rsp     (s1_rsp)
        );

        // fetch is always active and never stores
        addr_xlate #(
                .FETCH_PORT (1'b1)
        ) fetch_xlate (
                .access_valid (1'b1),
                .store        (1'b0),
                .vaddr        (fetch_vaddr),
                .crmd         (crmd),
                .asid         (asid),
                .dmw0         (dmw0),
                .dmw1         (dmw1),
                .tlb_rsp      (s0_rsp),
                .tlb_req      (s0_req),
                .result       (fetch_res)
        );

        addr_xlate #(
                .FETCH_PORT (1'b0)
        ) data_xlate (
                .access_valid (data_valid),
                .store        (data_store),
                .vaddr        (data_vaddr),
                .crmd         (crmd),
                .asid         (asid),
                .dmw0         (dmw0),
                .dmw1         (dmw1),
                .tlb_rsp      (s1_rsp),
                .tlb_req      (s1_req),
                .result       (data_res)
        );

endmodule

`default_nettype wire

// File: logic/tlb.sv
`timescale 1ns/100ps
`default_nettype none

module tlb #(
        parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES
) (
        input  wire                             clk,
        input  wire                             reset,
        input  wire                             tlb_we,
        input  wire [$clog2(TLB_ENTRIES)-1:0]   tlb_windex,
        input  mmu_pkg::tlb_entry_t             tlb_wentry,
        input  mmu_pkg::tlb_search_req_t        s0_req,
        input  mmu_pkg::tlb_search_req_t        s1_req,
        output mmu_pkg::tlb_search_rsp_t        s0_rsp,
        output mmu_pkg::tlb_search_rsp_t        s1_rsp
);

        import mmu_pkg::*;

        tlb_entry_t entries [TLB_ENTRIES];

        // only the exist bits are cleared
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < TLB_ENTRIES; i++) begin
                                entries[i].e <= 1'b0;
                        end
                end else if (tlb_we) begin
                        entries[tlb_windex] <= tlb_wentry;
                end
        end

        function automatic logic entry_match(input tlb_entry_t ent,
                                             input tlb_search_req_t req);
                logic vppn_eq;
                logic asid_ok;

                // 2M pages ignore the low vppn bits
                if (ent.ps == PS_2M) begin
                        vppn_eq = (ent.vppn[VPPN_W-1:9] == req.vppn[VPPN_W-1:9]);
                end else begin
                        vppn_eq = (ent.vppn == req.vppn);
                end
                asid_ok = ent.g || (ent.asid == req.asid);
                return ent.e && asid_ok && vppn_eq;
        endfunction

        function automatic tlb_search_rsp_t search(input tlb_search_req_t req);
                tlb_search_rsp_t rsp;
                logic            odd;

                rsp = '0;
                // walk downwards so the lowest matching index is kept
                for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
                        if (entry_match(entries[i], req)) begin
                                if (entries[i].ps == PS_2M) begin
                                        odd = req.vppn[8];
                                end else begin
                                        odd = req.va_bit12;
                                end
                                rsp.found = 1'b1;
                                rsp.index = TLB_IDX_W'(i);
                                rsp.ps    = entries[i].ps;
                                rsp.page  = entries[i].page[odd];
                        end
                end
                return rsp;
        endfunction

        always_comb begin
                s0_rsp = search(s0_req);
        end

        always_comb begin
                s1_rsp = search(s1_req);
        end

endmodule

`default_nettype wire

// File: logic/xlate_csr.sv
`timescale 1ns/100ps
`default_nettype none

module xlate_csr (
        input  wire                           clk,
        input  wire                           reset,
        input  wire                           csr_we,
        input  mmu_pkg::csr_num_t             csr_num,
        input  wire [31:0]                    csr_wdata,
        output mmu_pkg::crmd_t                crmd,
        output logic [mmu_pkg::ASID_W-1:0]    asid,
        output mmu_pkg::dmw_t                 dmw0,
        output mmu_pkg::dmw_t                 dmw1
);

        import mmu_pkg::*;

        crmd_t crmd_wr;
        dmw_t  dmw_wr;

        // defined fields of the written word
        always_comb begin
                crmd_wr       = '0;
                crmd_wr.plv   = csr_wdata[1:0];
                crmd_wr.ie    = csr_wdata[2];
                crmd_wr.da    = csr_wdata[3];
                crmd_wr.pg    = csr_wdata[4];
                crmd_wr.datf  = csr_wdata[6:5];
                crmd_wr.datm  = csr_wdata[8:7];

                dmw_wr        = '0;
                dmw_wr.plv0   = csr_wdata[0];
                dmw_wr.plv3   = csr_wdata[3];
                dmw_wr.mat    = csr_wdata[5:4];
                dmw_wr.pseg   = csr_wdata[27:25];
                dmw_wr.vseg   = csr_wdata[31:29];
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        // boot in direct address mode
                        crmd    <= '0;
                        crmd.da <= 1'b1;
                        asid    <= '0;
                        dmw0    <= '0;
                        dmw1    <= '0;
                end else if (csr_we) begin
                        case (csr_num)
                                CSR_CRMD: crmd <= crmd_wr;
                                CSR_ASID: asid <= csr_wdata[ASID_W-1:0];
                                CSR_DMW0: dmw0 <= dmw_wr;
                                CSR_DMW1: dmw1 <= dmw_wr;
                                default:  ;
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_mmu_top -f filelist.f

./obj_dir/Vtb_mmu_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tests/tb_mmu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mmu_top;

        import mmu_pkg::*;

        localparam int  NUM_CYCLES = 4000;
        localparam time RUN_LIMIT  = 100000;

        logic          clk = 1'b0;
        logic          reset;
        logic          csr_we;
        csr_num_t      csr_num;
        logic [31:0]   csr_wdata;
        logic          tlb_we;
        logic [3:0]    tlb_windex;
        tlb_entry_t    tlb_wentry;
        logic [31:0]   fetch_vaddr;
        logic          data_valid;
        logic          data_store;
        logic [31:0]   data_vaddr;
        xlate_result_t fetch_res;
        xlate_result_t data_res;

        // shadow state
        crmd_t       m_crmd;
        logic [9:0]  m_asid;
        dmw_t        m_dmw [2];
        tlb_entry_t  m_tlb [16];
        logic [18:0] pool [4];
        logic [1:0]  pool_wr;
        logic [31:0] lfsr = 32'h3c11;
        int          errors = 0;
        int          checks = 0;
        bit          timed_out = 1'b0;

        mmu_top #(
                .TLB_ENTRIES (16)
        ) dut0 (
                .clk         (clk),
                .reset       (reset),
                .csr_we      (csr_we),
                .csr_num     (csr_num),
                .csr_wdata   (csr_wdata),
                .tlb_we      (tlb_we),
                .tlb_windex  (tlb_windex),
                .tlb_wentry  (tlb_wentry),
                .fetch_vaddr (fetch_vaddr),
                .data_valid  (data_valid),
                .data_store  (data_store),
                .data_vaddr  (data_vaddr),
                .fetch_res   (fetch_res),
                .data_res    (data_res)
        );

        always #10 clk = ~clk;

        // galois lfsr, one step per bit
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;

                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
                        r = {r[30:0], lfsr[0]};
                end
                return r;
        endfunction

        function automatic dmw_t dmw_fields(input logic [31:0] w);
                dmw_t d;

                d      = '0;
                d.plv0 = w[0];
                d.plv3 = w[3];
                d.mat  = w[5:4];
                d.pseg = w[27:25];
                d.vseg = w[31:29];
                return d;
        endfunction

        function automatic logic [31:0] pick_vaddr();
                logic [31:0] va;

                va = rand_bits(32);
                // reuse a written vppn about half the time
                if (rand_bits(1) != 0) begin
                        va[31:13] = pool[2'(rand_bits(2))];
                end
                return va;
        endfunction

        function automatic xlate_result_t model_xlate(input bit fetch, input bit valid,
                        input bit st, input logic [31:0] va,
                        output bit chk_addr, output bit chk_cache);
                xlate_result_t r;
                int            hit;
                logic          vmatch;
                logic          odd;
                logic [5:0]    ps;
                tlb_page_t     pg;

                r         = '0;
                chk_addr  = 1'b1;
                chk_cache = 1'b1;
                hit       = -1;
                if (m_crmd.da) begin
                        r.paddr     = va;
                        r.cacheable = fetch ? (m_crmd.datf == 2'd1) : (m_crmd.datm == 2'd1);
                        return r;
                end
                for (int k = 0; k < 2; k++) begin
                        if (m_dmw[k].vseg == va[31:29] &&
                            ((m_crmd.plv == 2'd0 && m_dmw[k].plv0) ||
                             (m_crmd.plv == 2'd3 && m_dmw[k].plv3))) begin
                                r.paddr     = {m_dmw[k].pseg, va[28:0]};
                                r.cacheable = (m_dmw[k].mat == 2'd1);
                                return r;
                        end
                end
                for (int i = 0; i < 16; i++) begin
                        if (m_tlb[i].ps == PS_2M) begin
                                vmatch = (m_tlb[i].vppn[18:9] == va[31:22]);
                        end else begin
                                vmatch = (m_tlb[i].vppn == va[31:13]);
                        end
                        if (hit < 0 && m_tlb[i].e && vmatch &&
                            (m_tlb[i].g || m_tlb[i].asid == m_asid)) begin
                                hit = i;
                        end
                end
                if (hit < 0) begin
                        chk_addr   = 1'b0;
                        chk_cache  = 1'b0;
                        r.exc.tlbr = valid;
                        return r;
                end
                ps  = m_tlb[hit].ps;
                odd = (ps == PS_2M) ? va[21] : va[12];
                pg  = m_tlb[hit].page[odd];
                if (ps == PS_2M) begin
                        r.paddr = {pg.ppn[19:9], va[20:0]};
                end else begin
                        r.paddr = {pg.ppn, va[11:0]};
                end
                r.cacheable = (pg.mat == 2'd1);
                if (valid) begin
                        if (!pg.v) begin
                                r.exc.pif = fetch;
                                r.exc.pis = !fetch && st;
                                r.exc.pil = !fetch && !st;
                        end else if (m_crmd.plv > pg.plv) begin
                                r.exc.ppi = 1'b1;
                        end else if (!fetch && st && !pg.d) begin
                                r.exc.pme = 1'b1;
                        end
                end
                chk_addr = (r.exc == '0);
                return r;
        endfunction

        task automatic compare_port(input string name, input xlate_result_t got,
                        input xlate_result_t exp, input bit chk_addr, input bit chk_cache);
                checks++;
                if (got.exc !== exp.exc) begin
                        errors++;
                        $display("ERR %0t: %s faults %b, expected %b", $time, name, got.exc,
                                 exp.exc);
                end
                if (chk_addr && got.paddr !== exp.paddr) begin
                        errors++;
                        $display("ERR %0t: %s paddr %h, expected %h", $time, name, got.paddr,
                                 exp.paddr);
                end
                if (chk_cache && got.cacheable !== exp.cacheable) begin
                        errors++;
                        $display("ERR %0t: %s cacheable %b, expected %b", $time, name,
                                 got.cacheable, exp.cacheable);
                end
        endtask

        task automatic drive_inputs();
                tlb_entry_t  ent;
                logic [2:0]  sel;
                logic [31:0] w;

                sel    = 3'(rand_bits(3));
                csr_we = (2'(rand_bits(2)) == 2'd0);
                case (sel)
                        3'd0, 3'd1: csr_num = CSR_CRMD;
                        3'd2:       csr_num = CSR_ASID;
                        3'd3, 3'd4: csr_num = CSR_DMW0;
                        3'd5, 3'd6: csr_num = CSR_DMW1;
                        default:    csr_num = 14'h001;
                endcase
                w = rand_bits(32);
                // small asids so entries match
                if (csr_num == CSR_ASID) begin
                        w[9:2] = '0;
                end
                csr_wdata = w;

                ent      = '0;
                ent.e    = (2'(rand_bits(2)) != 2'd0);
                ent.vppn = (rand_bits(1) != 0) ? pool[2'(rand_bits(2))] : 19'(rand_bits(19));
                ent.ps   = (rand_bits(1) != 0) ? PS_2M : PS_4K;
                ent.asid = 10'(rand_bits(2));
                ent.g    = 1'(rand_bits(1));
                for (int p = 0; p < 2; p++) begin
                        ent.page[p].ppn = 20'(rand_bits(20));
                        ent.page[p].plv = 2'(rand_bits(2));
                        ent.page[p].mat = 2'(rand_bits(2));
                        ent.page[p].d   = 1'(rand_bits(1));
                        ent.page[p].v   = (2'(rand_bits(2)) != 2'd0);
                end
                tlb_we     = (2'(rand_bits(2)) == 2'd0);
                tlb_windex = 4'(rand_bits(4));
                tlb_wentry = ent;
                if (tlb_we) begin
                        pool[pool_wr] = ent.vppn;
                        pool_wr       = pool_wr + 2'd1;
                end

                fetch_vaddr = pick_vaddr();
                data_vaddr  = pick_vaddr();
                data_valid  = (2'(rand_bits(2)) != 2'd0);
                data_store  = 1'(rand_bits(1));
        endtask

        // a write lands on the coming edge
        task automatic update_shadow();
                if (csr_we) begin
                        case (csr_num)
                                CSR_CRMD: begin
                                        m_crmd      = '0;
                                        m_crmd.plv  = csr_wdata[1:0];
                                        m_crmd.ie   = csr_wdata[2];
                                        m_crmd.da   = csr_wdata[3];
                                        m_crmd.pg   = csr_wdata[4];
                                        m_crmd.datf = csr_wdata[6:5];
                                        m_crmd.datm = csr_wdata[8:7];
                                end
                                CSR_ASID: m_asid   = csr_wdata[9:0];
                                CSR_DMW0: m_dmw[0] = dmw_fields(csr_wdata);
                                CSR_DMW1: m_dmw[1] = dmw_fields(csr_wdata);
                                default:  ;
                        endcase
                end
                if (tlb_we) begin
                        m_tlb[tlb_windex] = tlb_wentry;
                end
        endtask

        initial begin
                int            cyc;
                bit            ca_f;
                bit            cc_f;
                bit            ca_d;
                bit            cc_d;
                xlate_result_t exp_f;
                xlate_result_t exp_d;

                reset       = 1'b1;
                csr_we      = 1'b0;
                csr_num     = '0;
                csr_wdata   = '0;
                tlb_we      = 1'b0;
                tlb_windex  = '0;
                tlb_wentry  = '0;
                fetch_vaddr = '0;
                data_valid  = 1'b0;
                data_store  = 1'b0;
                data_vaddr  = '0;
                m_crmd      = '0;
                m_crmd.da   = 1'b1;
                m_asid      = '0;
                m_dmw[0]    = '0;
                m_dmw[1]    = '0;
                pool_wr     = '0;
                for (int i = 0; i < 16; i++) begin
                        m_tlb[i] = '0;
                end
                for (int i = 0; i < 4; i++) begin
                        pool[i] = '0;
                end

                for (cyc = 0; cyc < 4; cyc++) begin
                        @(posedge clk);
                end
                #2;
                reset = 1'b0;

                cyc = 0;
                while (cyc < NUM_CYCLES && !timed_out) begin
                        drive_inputs();
                        #17;
                        exp_f = model_xlate(1'b1, 1'b1, 1'b0, fetch_vaddr, ca_f, cc_f);
                        exp_d = model_xlate(1'b0, data_valid, data_store, data_vaddr, ca_d, cc_d);
                        compare_port("fetch", fetch_res, exp_f, ca_f, cc_f);
                        compare_port("data", data_res, exp_d, ca_d, cc_d);
                        update_shadow();
                        @(posedge clk);
                        #2;
                        cyc++;
                        if ($time > RUN_LIMIT) begin
                                timed_out = 1'b1;
                                $display("timeout: run did not finish within %0d ns", RUN_LIMIT);
                        end
                end

                $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
                if (errors == 0 && !timed_out) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire
